/* build.f */
+incdir+design
design/rv_id_pkg.sv
design/forward_if.sv
design/dec_if.sv
design/rv_decoder.sv
design/operand_bypass.sv
design/id_ex_reg.sv
design/id_stage.sv
bench/tb_id_stage.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_id_stage
RTL_TOP   := id_stage
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log
LFLAGS    := --lint-only --timing --timescale 1ns/1ns
VFLAGS    := --binary --timing --timescale 1ns/1ns

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "sim: failure in $(LOG)"; exit 1; fi
	@grep -q "Simulation PASSED" $(LOG) || (echo "sim: no result in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tb_id_stage.sv */
`timescale 1ns/1ns
`include "rv_id_config.svh"

module tb_id_stage;

    localparam int MAX_CYCLES = 2000;

    logic                  clk;
    logic                  arst_n_i;
    rv_id_pkg::word_t      pc_i;
    rv_id_pkg::inst_t      inst_i;
    rv_id_pkg::word_t      reg1_data_i;
    rv_id_pkg::word_t      reg2_data_i;
    logic                  ex_ld_i;
    logic                  ex_wreg_i;
    rv_id_pkg::reg_addr_t  ex_wd_i;
    rv_id_pkg::word_t      ex_wdata_i;
    logic                  mem_wreg_i;
    rv_id_pkg::reg_addr_t  mem_wd_i;
    rv_id_pkg::word_t      mem_wdata_i;
    logic                  reg1_read_o;
    logic                  reg2_read_o;
    rv_id_pkg::reg_addr_t  reg1_addr_o;
    rv_id_pkg::reg_addr_t  reg2_addr_o;
    rv_id_pkg::word_t      pc_o;
    rv_id_pkg::alu_op_t    aluop_o;
    rv_id_pkg::alu_sel_t   alusel_o;
    rv_id_pkg::word_t      reg1_o;
    rv_id_pkg::word_t      reg2_o;
    rv_id_pkg::reg_addr_t  wd_o;
    logic                  wreg_o;
    rv_id_pkg::word_t      offset_o;
    logic                  id_stall_o;

    rv_id_pkg::word_t      rng_state;
    int                    err_cnt;
    int                    chk_cnt;
    int                    test_cnt;
    int                    err_at_start;
    logic                  reset_timeout;

    id_stage DUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        arst_n_i = 1'b0;
        repeat (16) @(posedge clk);
        #5;
        arst_n_i = 1'b1;
    end

    // hang guard
    initial begin
        #(MAX_CYCLES * 100);
        $display("run did not finish within %0d cycles", MAX_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    function automatic rv_id_pkg::word_t next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // register file contents seen by the stage
    function automatic rv_id_pkg::word_t rf_pat(input rv_id_pkg::reg_addr_t a);
        return {a, ~a, 8'ha5, a, 9'h0cf};
    endfunction

    function automatic rv_id_pkg::inst_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
        input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic rv_id_pkg::inst_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rv_id_pkg::inst_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [6:0] op);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
    endfunction

    function automatic rv_id_pkg::inst_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
    endfunction

    function automatic rv_id_pkg::inst_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
    endfunction

    task automatic check_word(input string what, input rv_id_pkg::word_t got,
        input rv_id_pkg::word_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("** Error @ %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input string what, input rv_id_pkg::reg_addr_t got,
        input rv_id_pkg::reg_addr_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("** Error @ %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_aluop(input string what, input rv_id_pkg::alu_op_t got,
        input rv_id_pkg::alu_op_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("** Error @ %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_alusel(input string what, input rv_id_pkg::alu_sel_t got,
        input rv_id_pkg::alu_sel_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("** Error @ %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("** Error @ %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic next_edge();
        @(posedge clk);
        #5;
    endtask

    task automatic drive_inst(input rv_id_pkg::word_t pc, input rv_id_pkg::inst_t inst);
        pc_i        = pc;
        inst_i      = inst;
        reg1_data_i = rf_pat(inst[19:15]);
        reg2_data_i = rf_pat(inst[24:20]);
    endtask

    task automatic set_bypass(input logic ld, input logic ewreg, input logic [4:0] ewd,
        input rv_id_pkg::word_t ewdata, input logic mwreg, input logic [4:0] mwd,
        input rv_id_pkg::word_t mwdata);
        ex_ld_i     = ld;
        ex_wreg_i   = ewreg;
        ex_wd_i     = ewd;
        ex_wdata_i  = ewdata;
        mem_wreg_i  = mwreg;
        mem_wd_i    = mwd;
        mem_wdata_i = mwdata;
    endtask

    task automatic check_stage(input string name, input rv_id_pkg::alu_op_t aluop,
        input rv_id_pkg::alu_sel_t alusel, input logic wreg, input rv_id_pkg::reg_addr_t wd,
        input rv_id_pkg::word_t r1, input rv_id_pkg::word_t r2, input rv_id_pkg::word_t off,
        input rv_id_pkg::word_t pc);
        check_aluop({name, " aluop"}, aluop_o, aluop);
        check_alusel({name, " alusel"}, alusel_o, alusel);
        check_bit({name, " wreg"}, wreg_o, wreg);
        check_addr({name, " wd"}, wd_o, wd);
        check_word({name, " reg1"}, reg1_o, r1);
        check_word({name, " reg2"}, reg2_o, r2);
        check_word({name, " offset"}, offset_o, off);
        check_word({name, " pc"}, pc_o, pc);
    endtask

    // one instruction with idle hazards and its result one edge later
    task automatic run_inst(input string name, input rv_id_pkg::inst_t inst, input logic rd1,
        input logic rd2, input rv_id_pkg::alu_op_t aluop, input rv_id_pkg::alu_sel_t alusel,
        input logic wreg, input rv_id_pkg::word_t r1, input rv_id_pkg::word_t r2,
        input rv_id_pkg::word_t off);
        rv_id_pkg::word_t pc;
        pc = next_rand();
        drive_inst(pc, inst);
        #1;
        check_bit({name, " reg1_read"}, reg1_read_o, rd1);
        check_bit({name, " reg2_read"}, reg2_read_o, rd2);
        check_addr({name, " reg1_addr"}, reg1_addr_o, inst[19:15]);
        check_addr({name, " reg2_addr"}, reg2_addr_o, inst[24:20]);
        check_bit({name, " id_stall"}, id_stall_o, 1'b0);
        next_edge();
        check_stage(name, aluop, alusel, wreg, inst[11:7], r1, r2, off, pc);
    endtask

    task automatic begin_test();
        test_cnt++;
        err_at_start = err_cnt;
    endtask

    task automatic end_test(input string name);
        $display("test %-12s done, %0d errors", name, err_cnt - err_at_start);
    endtask

    task automatic test_reset();
        int waited;
        begin_test();
        repeat (4) @(posedge clk);
        #5;
        check_stage("in reset", `EX_NOP, `RES_NOP, 1'b0, '0, '0, '0, '0, '0);
        check_bit("in reset id_stall", id_stall_o, 1'b0);
        waited = 0;
        while (!arst_n_i && waited < 40) begin
            @(posedge clk);
            #8;
            waited++;
        end
        if (!arst_n_i) begin
            reset_timeout = 1'b1;
            $display("reset was not released within 40 cycles");
        end else begin
            next_edge();
            check_stage("after reset", `EX_NOP, `RES_NOP, 1'b0, '0, '0, '0, '0, '0);
            check_bit("after reset id_stall", id_stall_o, 1'b0);
        end
        end_test("reset");
    endtask

    task automatic test_opimm_utype();
        rv_id_pkg::word_t f;
        rv_id_pkg::word_t e;
        logic [4:0]       rd;
        logic [4:0]       rs1;
        begin_test();
        repeat (4) begin
            f   = next_rand();
            rd  = f[4:0];
            rs1 = f[9:5];
            e   = {{20{f[31]}}, f[31:20]};
            run_inst("addi", enc_i(f[31:20], rs1, `RV_F3_ADD, rd, `RV_OP_OPI), 1'b1, 1'b0,
                     `EX_ADD, `RES_ARITH, 1'b1, rf_pat(rs1), e, e);
            run_inst("slti", enc_i(f[31:20], rs1, `RV_F3_SLT, rd, `RV_OP_OPI), 1'b1, 1'b0,
                     `EX_SLT, `RES_ARITH, 1'b1, rf_pat(rs1), e, e);
            run_inst("xori", enc_i(f[31:20], rs1, `RV_F3_XOR, rd, `RV_OP_OPI), 1'b1, 1'b0,
                     `EX_XOR, `RES_LOGIC, 1'b1, rf_pat(rs1), e, e);
            // shift amount is zero-extended
            e = {27'h0, f[14:10]};
            run_inst("slli", enc_i({`RV_F7_BASE, f[14:10]}, rs1, `RV_F3_SLL, rd, `RV_OP_OPI),
                     1'b1, 1'b0, `EX_SLL, `RES_SHIFT, 1'b1, rf_pat(rs1), e, e);
            run_inst("srai", enc_i({`RV_F7_ALT, f[14:10]}, rs1, `RV_F3_SR, rd, `RV_OP_OPI),
                     1'b1, 1'b0, `EX_SRA, `RES_SHIFT, 1'b1, rf_pat(rs1), e, e);
            e = {f[31:12], 12'h000};
            run_inst("lui", {f[31:12], rd, `RV_OP_LUI}, 1'b0, 1'b0,
                     `EX_OR, `RES_LOGIC, 1'b1, e, e, e);
            run_inst("auipc", {f[31:12], rd, `RV_OP_AUIPC}, 1'b0, 1'b0,
                     `EX_AUIPC, `RES_ARITH, 1'b1, e, e, e);
        end
        end_test("opimm_u");
    endtask

    task automatic test_mem_ctrl();
        rv_id_pkg::word_t f;
        rv_id_pkg::word_t e;
        logic [4:0]       rd;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        begin_test();
        repeat (4) begin
            f   = next_rand();
            rd  = f[4:0];
            rs1 = f[9:5];
            rs2 = f[14:10];
            e   = {{20{f[31]}}, f[31:20]};
            run_inst("lw", enc_i(f[31:20], rs1, `RV_F3_LW, rd, `RV_OP_LOAD), 1'b1, 1'b0,
                     `EX_LW, `RES_LD_ST, 1'b1, rf_pat(rs1), e, e);
            run_inst("lbu", enc_i(f[31:20], rs1, `RV_F3_LBU, rd, `RV_OP_LOAD), 1'b1, 1'b0,
                     `EX_LBU, `RES_LD_ST, 1'b1, rf_pat(rs1), e, e);
            run_inst("jalr", enc_i(f[31:20], rs1, `RV_F3_JALR, rd, `RV_OP_JALR), 1'b1, 1'b0,
                     `EX_JALR, `RES_JAL, 1'b1, rf_pat(rs1), e, e);
            run_inst("sw", enc_s(f[31:20], rs2, rs1, `RV_F3_SW, `RV_OP_STORE), 1'b1, 1'b1,
                     `EX_SW, `RES_LD_ST, 1'b0, rf_pat(rs1), rf_pat(rs2), e);
            run_inst("sh", enc_s(f[31:20], rs2, rs1, `RV_F3_SH, `RV_OP_STORE), 1'b1, 1'b1,
                     `EX_SH, `RES_LD_ST, 1'b0, rf_pat(rs1), rf_pat(rs2), e);
            // branch offsets are even with the sign at bit 12
            e = {{19{f[31]}}, f[31:20], 1'b0};
            run_inst("beq", enc_b({f[31:20], 1'b0}, rs2, rs1, `RV_F3_BEQ), 1'b1, 1'b1,
                     `EX_BEQ, `RES_NOP, 1'b0, rf_pat(rs1), rf_pat(rs2), e);
            run_inst("bgeu", enc_b({f[31:20], 1'b0}, rs2, rs1, `RV_F3_BGEU), 1'b1, 1'b1,
                     `EX_BGEU, `RES_NOP, 1'b0, rf_pat(rs1), rf_pat(rs2), e);
            e = {{11{f[31]}}, f[31:12], 1'b0};
            run_inst("jal", enc_j({f[31:12], 1'b0}, rd), 1'b0, 1'b0,
                     `EX_JAL, `RES_JAL, 1'b1, e, e, e);
        end
        end_test("mem_ctrl");
    endtask

    task automatic test_forwarding();
        rv_id_pkg::inst_t inst;
        rv_id_pkg::word_t exd;
        rv_id_pkg::word_t md;
        begin_test();
        inst = enc_r(`RV_F7_BASE, 5'd7, 5'd7, `RV_F3_ADD, 5'd20, `RV_OP_OP);
        exd  = next_rand();
        md   = next_rand();
        set_bypass(1'b0, 1'b1, 5'd7, exd, 1'b1, 5'd7, md);
        run_inst("ex over mem", inst, 1'b1, 1'b1, `EX_ADD, `RES_ARITH, 1'b1, exd, exd, '0);
        set_bypass(1'b0, 1'b1, 5'd8, exd, 1'b1, 5'd7, md);
        run_inst("mem only", inst, 1'b1, 1'b1, `EX_ADD, `RES_ARITH, 1'b1, md, md, '0);
        set_bypass(1'b0, 1'b1, 5'd8, exd, 1'b1, 5'd9, md);
        run_inst("no match", inst, 1'b1, 1'b1, `EX_ADD, `RES_ARITH, 1'b1,
                 rf_pat(5'd7), rf_pat(5'd7), '0);
        // matching address but no write enable
        set_bypass(1'b0, 1'b0, 5'd7, exd, 1'b1, 5'd7, md);
        run_inst("ex no wreg", inst, 1'b1, 1'b1, `EX_ADD, `RES_ARITH, 1'b1, md, md, '0);
        set_bypass(1'b0, 1'b0, 5'd7, exd, 1'b0, 5'd7, md);
        run_inst("mem no wreg", inst, 1'b1, 1'b1, `EX_ADD, `RES_ARITH, 1'b1,
                 rf_pat(5'd7), rf_pat(5'd7), '0);
        set_bypass(1'b0, 1'b0, '0, '0, 1'b0, '0, '0);
        end_test("forwarding");
    endtask

    task automatic test_load_use();
        rv_id_pkg::inst_t inst;
        rv_id_pkg::word_t pc;
        rv_id_pkg::word_t md;
        begin_test();
        inst = enc_r(`RV_F7_ALT, 5'd9, 5'd3, `RV_F3_ADD, 5'd12, `RV_OP_OP);
        pc   = next_rand();
        md   = next_rand();
        drive_inst(pc, inst);
        set_bypass(1'b1, 1'b1, 5'd9, next_rand(), 1'b0, '0, '0);
        #1;
        check_bit("load-use id_stall", id_stall_o, 1'b1);
        next_edge();
        check_stage("bubble", `EX_NOP, `RES_NOP, 1'b0, '0, '0, '0, '0, '0);
        // load has moved on to MEM while the instruction is held upstream
        set_bypass(1'b0, 1'b0, '0, '0, 1'b1, 5'd9, md);
        #1;
        check_bit("released id_stall", id_stall_o, 1'b0);
        next_edge();
        check_stage("held sub", `EX_SUB, `RES_ARITH, 1'b1, 5'd12, rf_pat(5'd3), md, '0, pc);
        set_bypass(1'b0, 1'b0, '0, '0, 1'b0, '0, '0);
        end_test("load_use");
    endtask

    task automatic test_undefined();
        rv_id_pkg::word_t f;
        begin_test();
        f = next_rand();
        run_inst("bad opcode", {f[31:7], 7'b1111111}, 1'b0, 1'b0,
                 `EX_NOP, `RES_NOP, 1'b0, '0, '0, '0);
        run_inst("bad funct7", enc_r(7'b0000001, f[24:20], f[19:15], `RV_F3_ADD, f[11:7],
                 `RV_OP_OP), 1'b0, 1'b0, `EX_NOP, `RES_NOP, 1'b0, '0, '0, '0);
        end_test("undefined");
    endtask

    initial begin
        rng_state     = 32'd68585;
        err_cnt       = 0;
        chk_cnt       = 0;
        test_cnt      = 0;
        err_at_start  = 0;
        reset_timeout = 1'b0;
        drive_inst('0, '0);
        set_bypass(1'b0, 1'b0, '0, '0, 1'b0, '0, '0);
        test_reset();
        if (!reset_timeout) begin
            test_opimm_utype();
            test_mem_ctrl();
            test_forwarding();
            test_load_use();
            test_undefined();
        end
        $display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0 && !reset_timeout) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* design/id_stage.sv */
`timescale 1ns/1ns

module id_stage (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  rv_id_pkg::word_t      pc_i,
    input  rv_id_pkg::inst_t      inst_i,
    input  rv_id_pkg::word_t      reg1_data_i,
    input  rv_id_pkg::word_t      reg2_data_i,
    input  logic                  ex_ld_i,
    input  logic                  ex_wreg_i,
    input  rv_id_pkg::reg_addr_t  ex_wd_i,
    input  rv_id_pkg::word_t      ex_wdata_i,
    input  logic                  mem_wreg_i,
    input  rv_id_pkg::reg_addr_t  mem_wd_i,
    input  rv_id_pkg::word_t      mem_wdata_i,
    output logic                  reg1_read_o,
    output logic                  reg2_read_o,
    output rv_id_pkg::reg_addr_t  reg1_addr_o,
    output rv_id_pkg::reg_addr_t  reg2_addr_o,
    output rv_id_pkg::word_t      pc_o,
    output rv_id_pkg::alu_op_t    aluop_o,
    output rv_id_pkg::alu_sel_t   alusel_o,
    output rv_id_pkg::word_t      reg1_o,
    output rv_id_pkg::word_t      reg2_o,
    output rv_id_pkg::reg_addr_t  wd_o,
    output logic                  wreg_o,
    output rv_id_pkg::word_t      offset_o,
    output logic                  id_stall_o
);

    rv_id_pkg::word_t  src1_op;
    rv_id_pkg::word_t  src2_op;
    logic              src1_stall;
    logic              src2_stall;

    forward_if fwd_bus ();
    dec_if     dec_bus ();

    // bypass bundle from the later stages
    assign fwd_bus.ex_ld     = ex_ld_i;
    assign fwd_bus.ex_wreg   = ex_wreg_i;
    assign fwd_bus.ex_wd     = ex_wd_i;
    assign fwd_bus.ex_wdata  = ex_wdata_i;
    assign fwd_bus.mem_wreg  = mem_wreg_i;
    assign fwd_bus.mem_wd    = mem_wd_i;
    assign fwd_bus.mem_wdata = mem_wdata_i;

    rv_decoder u_dec (
        .inst_i      (inst_i),
        .reg1_read_o (reg1_read_o),
        .reg2_read_o (reg2_read_o),
        .reg1_addr_o (reg1_addr_o),
        .reg2_addr_o (reg2_addr_o),
        .dec         (dec_bus.dec)
    );

    operand_bypass u_src1 (
        .read_i    (reg1_read_o),
        .addr_i    (reg1_addr_o),
        .rf_data_i (reg1_data_i),
        .fwd       (fwd_bus.dst),
        .dec       (dec_bus.opsel),
        .operand_o (src1_op),
        .stall_o   (src1_stall)
    );

    operand_bypass u_src2 (
        .read_i    (reg2_read_o),
        .addr_i    (reg2_addr_o),
        .rf_data_i (reg2_data_i),
        .fwd       (fwd_bus.dst),
        .dec       (dec_bus.opsel),
        .operand_o (src2_op),
        .stall_o   (src2_stall)
    );

    id_ex_reg u_id_ex (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .pc_i         (pc_i),
        .dec          (dec_bus.stage),
        .reg1_i       (src1_op),
        .reg2_i       (src2_op),
        .reg1_stall_i (src1_stall),
        .reg2_stall_i (src2_stall),
        .id_stall_o   (id_stall_o),
        .pc_o         (pc_o),
        .aluop_o      (aluop_o),
        .alusel_o     (alusel_o),
        .reg1_o       (reg1_o),
        .reg2_o       (reg2_o),
        .offset_o     (offset_o),
        .wd_o         (wd_o),
        .wreg_o       (wreg_o)
    );

endmodule

/* design/id_ex_reg.sv */
`timescale 1ns/1ns
`include "rv_id_config.svh"

module id_ex_reg (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  rv_id_pkg::word_t      pc_i,
    dec_if.stage                  dec,
    input  rv_id_pkg::word_t      reg1_i,
    input  rv_id_pkg::word_t      reg2_i,
    input  logic                  reg1_stall_i,
    input  logic                  reg2_stall_i,
    output logic                  id_stall_o,
    output rv_id_pkg::word_t      pc_o,
    output rv_id_pkg::alu_op_t    aluop_o,
    output rv_id_pkg::alu_sel_t   alusel_o,
    output rv_id_pkg::word_t      reg1_o,
    output rv_id_pkg::word_t      reg2_o,
    output rv_id_pkg::word_t      offset_o,
    output rv_id_pkg::reg_addr_t  wd_o,
    output logic                  wreg_o
);

    assign id_stall_o = reg1_stall_i | reg2_stall_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_o     <= '0;
            aluop_o  <= `EX_NOP;
            alusel_o <= `RES_NOP;
            reg1_o   <= '0;
            reg2_o   <= '0;
            offset_o <= '0;
            wd_o     <= '0;
            wreg_o   <= 1'b0;
        end else if (id_stall_o) begin
            // bubble into EX while upstream holds the instruction
            pc_o     <= '0;
            aluop_o  <= `EX_NOP;
            alusel_o <= `RES_NOP;
            reg1_o   <= '0;
            reg2_o   <= '0;
            offset_o <= '0;
            wd_o     <= '0;
            wreg_o   <= 1'b0;
        end else begin
            pc_o     <= pc_i;
            aluop_o  <= dec.aluop;
            alusel_o <= dec.alusel;
            reg1_o   <= reg1_i;
            reg2_o   <= reg2_i;
            offset_o <= dec.imm;
            wd_o     <= dec.wd;
            wreg_o   <= dec.wreg;
        end
    end

endmodule

/* design/operand_bypass.sv */
`timescale 1ns/1ns

module operand_bypass (
    input  logic                  read_i,
    input  rv_id_pkg::reg_addr_t  addr_i,
    input  rv_id_pkg::word_t      rf_data_i,
    forward_if.dst                fwd,
    dec_if.opsel                  dec,
    output rv_id_pkg::word_t      operand_o,
    output logic                  stall_o
);

    logic ex_hit;
    logic mem_hit;

    // x0 is compared like any other register
    assign ex_hit  = fwd.ex_wreg && (fwd.ex_wd == addr_i);
    assign mem_hit = fwd.mem_wreg && (fwd.mem_wd == addr_i);

    // load in EX still has no data for us
    assign stall_o = read_i && fwd.ex_ld && (fwd.ex_wd == addr_i);

    always_comb begin
        if (stall_o) begin
            operand_o = '0;
        end else if (read_i && ex_hit) begin
            operand_o = fwd.ex_wdata;
        end else if (read_i && mem_hit) begin
            operand_o = fwd.mem_wdata;
        end else if (read_i) begin
            operand_o = rf_data_i;
        end else begin
            // unread source carries the immediate
            operand_o = dec.imm;
        end
    end

endmodule

/* design/rv_decoder.sv */
`timescale 1ns/1ns
`include "rv_id_config.svh"

module rv_decoder (
    input  rv_id_pkg::inst_t      inst_i,
    output logic                  reg1_read_o,
    output logic                  reg2_read_o,
    output rv_id_pkg::reg_addr_t  reg1_addr_o,
    output rv_id_pkg::reg_addr_t  reg2_addr_o,
    dec_if.dec                    dec
);

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    rv_id_pkg::reg_addr_t  rd;
    rv_id_pkg::word_t      i_imm;
    rv_id_pkg::word_t      s_imm;
    rv_id_pkg::word_t      sb_imm;
    rv_id_pkg::word_t      u_imm;
    rv_id_pkg::word_t      uj_imm;
    rv_id_pkg::word_t      shamt_imm;
    logic                  f7_chk;
    logic                  f7_ok;
    logic                  is_shift;
    logic                  known;

    assign opcode      = inst_i[6:0];
    assign rd          = inst_i[11:7];
    assign funct3      = inst_i[14:12];
    assign funct7      = inst_i[31:25];
    assign reg1_addr_o = inst_i[19:15];
    assign reg2_addr_o = inst_i[24:20];

    assign i_imm     = {{20{inst_i[31]}}, inst_i[31:20]};
    assign s_imm     = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign sb_imm    = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                        inst_i[11:8], 1'b0};
    assign u_imm     = {inst_i[31:12], 12'h000};
    assign uj_imm    = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                        inst_i[30:21], 1'b0};
    assign shamt_imm = {27'h0, inst_i[24:20]};

    // funct7 matters for all of OP and for the OP-IMM shifts
    assign is_shift = (funct3 == `RV_F3_SLL) || (funct3 == `RV_F3_SR);
    assign f7_chk   = (opcode == `RV_OP_OP) || is_shift;
    assign f7_ok    = !f7_chk || (funct7 == `RV_F7_BASE) ||
                      ((funct7 == `RV_F7_ALT) &&
                       ((funct3 == `RV_F3_SR) ||
                        ((funct3 == `RV_F3_ADD) && (opcode == `RV_OP_OP))));

    // operation and result class
    always_comb begin
        dec.aluop  = `EX_NOP;
        dec.alusel = `RES_NOP;
        case (opcode)
            `RV_OP_OPI, `RV_OP_OP: begin
                if (f7_ok) begin
                    case (funct3)
                        `RV_F3_ADD: begin
                            dec.aluop  = (opcode == `RV_OP_OP && funct7 == `RV_F7_ALT) ?
                                         `EX_SUB : `EX_ADD;
                            dec.alusel = `RES_ARITH;
                        end
                        `RV_F3_SLT: begin
                            dec.aluop  = `EX_SLT;
                            dec.alusel = `RES_ARITH;
                        end
                        `RV_F3_SLTU: begin
                            dec.aluop  = `EX_SLTU;
                            dec.alusel = `RES_ARITH;
                        end
                        `RV_F3_XOR: begin
                            dec.aluop  = `EX_XOR;
                            dec.alusel = `RES_LOGIC;
                        end
                        `RV_F3_OR: begin
                            dec.aluop  = `EX_OR;
                            dec.alusel = `RES_LOGIC;
                        end
                        `RV_F3_AND: begin
                            dec.aluop  = `EX_AND;
                            dec.alusel = `RES_LOGIC;
                        end
                        `RV_F3_SLL: begin
                            dec.aluop  = `EX_SLL;
                            dec.alusel = `RES_SHIFT;
                        end
                        default: begin
                            dec.aluop  = (funct7 == `RV_F7_ALT) ? `EX_SRA : `EX_SRL;
                            dec.alusel = `RES_SHIFT;
                        end
                    endcase
                end
            end
            `RV_OP_LOAD: begin
                dec.alusel = `RES_LD_ST;
                case (funct3)
                    `RV_F3_LB:  dec.aluop = `EX_LB;
                    `RV_F3_LH:  dec.aluop = `EX_LH;
                    `RV_F3_LW:  dec.aluop = `EX_LW;
                    `RV_F3_LBU: dec.aluop = `EX_LBU;
                    `RV_F3_LHU: dec.aluop = `EX_LHU;
                    default:    dec.alusel = `RES_NOP;
                endcase
            end
            `RV_OP_STORE: begin
                dec.alusel = `RES_LD_ST;
                case (funct3)
                    `RV_F3_SB: dec.aluop = `EX_SB;
                    `RV_F3_SH: dec.aluop = `EX_SH;
                    `RV_F3_SW: dec.aluop = `EX_SW;
                    default:   dec.alusel = `RES_NOP;
                endcase
            end
            `RV_OP_BRANCH: begin
                // branches produce no register result
                case (funct3)
                    `RV_F3_BEQ:  dec.aluop = `EX_BEQ;
                    `RV_F3_BNE:  dec.aluop = `EX_BNE;
                    `RV_F3_BLT:  dec.aluop = `EX_BLT;
                    `RV_F3_BGE:  dec.aluop = `EX_BGE;
                    `RV_F3_BLTU: dec.aluop = `EX_BLTU;
                    `RV_F3_BGEU: dec.aluop = `EX_BGEU;
                    default:     dec.aluop = `EX_NOP;
                endcase
            end
            `RV_OP_JAL: begin
                dec.aluop  = `EX_JAL;
                dec.alusel = `RES_JAL;
            end
            `RV_OP_JALR: begin
                if (funct3 == `RV_F3_JALR) begin
                    dec.aluop  = `EX_JALR;
                    dec.alusel = `RES_JAL;
                end
            end
            `RV_OP_LUI: begin
                // both operands carry the immediate
                dec.aluop  = `EX_OR;
                dec.alusel = `RES_LOGIC;
            end
            `RV_OP_AUIPC: begin
                dec.aluop  = `EX_AUIPC;
                dec.alusel = `RES_ARITH;
            end
            default: begin
            end
        endcase
    end

    assign known  = (dec.aluop != `EX_NOP);
    assign dec.wd = rd;

    // register reads, write enable and immediate per format
    always_comb begin
        dec.wreg    = 1'b0;
        reg1_read_o = 1'b0;
        reg2_read_o = 1'b0;
        dec.imm     = '0;
        if (known) begin
            case (opcode)
                `RV_OP_OPI: begin
                    dec.wreg    = 1'b1;
                    reg1_read_o = 1'b1;
                    dec.imm     = is_shift ? shamt_imm : i_imm;
                end
                `RV_OP_OP: begin
                    dec.wreg    = 1'b1;
                    reg1_read_o = 1'b1;
                    reg2_read_o = 1'b1;
                end
                `RV_OP_LOAD, `RV_OP_JALR: begin
                    dec.wreg    = 1'b1;
                    reg1_read_o = 1'b1;
                    dec.imm     = i_imm;
                end
                `RV_OP_STORE: begin
                    reg1_read_o = 1'b1;
                    reg2_read_o = 1'b1;
                    dec.imm     = s_imm;
                end
                `RV_OP_BRANCH: begin
                    reg1_read_o = 1'b1;
                    reg2_read_o = 1'b1;
                    dec.imm     = sb_imm;
                end
                `RV_OP_JAL: begin
                    dec.wreg = 1'b1;
                    dec.imm  = uj_imm;
                end
                `RV_OP_LUI, `RV_OP_AUIPC: begin
                    dec.wreg = 1'b1;
                    dec.imm  = u_imm;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

/* design/dec_if.sv */
`timescale 1ns/1ns

// decoded control and immediate
interface dec_if;
    rv_id_pkg::alu_op_t    aluop;
    rv_id_pkg::alu_sel_t   alusel;
    logic                  wreg;
    rv_id_pkg::reg_addr_t  wd;
    rv_id_pkg::word_t      imm;

    modport dec (
        output aluop, alusel, wreg, wd, imm
    );

    modport stage (
        input aluop, alusel, wreg, wd, imm
    );

    // operand select only needs the immediate
    modport opsel (
        input imm
    );
endinterface

/* design/forward_if.sv */
`timescale 1ns/1ns

// bypass sources from the EX and MEM stages
interface forward_if;
    logic                  ex_ld;
    logic                  ex_wreg;
    rv_id_pkg::reg_addr_t  ex_wd;
    rv_id_pkg::word_t      ex_wdata;
    logic                  mem_wreg;
    rv_id_pkg::reg_addr_t  mem_wd;
    rv_id_pkg::word_t      mem_wdata;

    modport src (
        output ex_ld, ex_wreg, ex_wd, ex_wdata, mem_wreg, mem_wd, mem_wdata
    );

    modport dst (
        input ex_ld, ex_wreg, ex_wd, ex_wdata, mem_wreg, mem_wd, mem_wdata
    );
endinterface

/* design/rv_id_pkg.sv */
`include "rv_id_config.svh"

package rv_id_pkg;

    // data word or address
    typedef logic [`RV_XLEN-1:0] word_t;

    // raw instruction
    typedef logic [`RV_XLEN-1:0] inst_t;

    // register file index
    typedef logic [`RV_REG_AW-1:0] reg_addr_t;

    // ALU operation code
    typedef logic [`RV_ALUOP_W-1:0] alu_op_t;

    // result select code
    typedef logic [`RV_ALUSEL_W-1:0] alu_sel_t;

endpackage

/* design/rv_id_config.svh */
`ifndef RV_ID_CONFIG_SVH
`define RV_ID_CONFIG_SVH

// datapath widths
`define RV_XLEN         32
`define RV_REG_AW       5
`define RV_ALUOP_W      8
`define RV_ALUSEL_W     3

// major opcodes in inst[6:0]
`define RV_OP_OPI       7'b0010011
`define RV_OP_OP        7'b0110011
`define RV_OP_LOAD      7'b0000011
`define RV_OP_STORE     7'b0100011
`define RV_OP_BRANCH    7'b1100011
`define RV_OP_JAL       7'b1101111
`define RV_OP_JALR      7'b1100111
`define RV_OP_LUI       7'b0110111
`define RV_OP_AUIPC     7'b0010111

// funct3 for OP and OP-IMM
`define RV_F3_ADD       3'b000
`define RV_F3_SLL       3'b001
`define RV_F3_SLT       3'b010
`define RV_F3_SLTU      3'b011
`define RV_F3_XOR       3'b100
`define RV_F3_SR        3'b101
`define RV_F3_OR        3'b110
`define RV_F3_AND       3'b111

// funct3 for loads and stores
`define RV_F3_LB        3'b000
`define RV_F3_LH        3'b001
`define RV_F3_LW        3'b010
`define RV_F3_LBU       3'b100
`define RV_F3_LHU       3'b101
`define RV_F3_SB        3'b000
`define RV_F3_SH        3'b001
`define RV_F3_SW        3'b010

// funct3 for branches and JALR
`define RV_F3_BEQ       3'b000
`define RV_F3_BNE       3'b001
`define RV_F3_BLT       3'b100
`define RV_F3_BGE       3'b101
`define RV_F3_BLTU      3'b110
`define RV_F3_BGEU      3'b111
`define RV_F3_JALR      3'b000

// funct7 ALT selects SUB and SRA
`define RV_F7_BASE      7'b0000000
`define RV_F7_ALT       7'b0100000

// ALU operation codes
`define EX_NOP          8'h00
`define EX_ADD          8'h01
`define EX_SUB          8'h02
`define EX_SLT          8'h03
`define EX_SLTU         8'h04
`define EX_XOR          8'h05
`define EX_OR           8'h06
`define EX_AND          8'h07
`define EX_SLL          8'h08
`define EX_SRL          8'h09
`define EX_SRA          8'h0a
`define EX_LB           8'h10
`define EX_LH           8'h11
`define EX_LW           8'h12
`define EX_LBU          8'h13
`define EX_LHU          8'h14
`define EX_SB           8'h18
`define EX_SH           8'h19
`define EX_SW           8'h1a
`define EX_BEQ          8'h20
`define EX_BNE          8'h21
`define EX_BLT          8'h22
`define EX_BGE          8'h23
`define EX_BLTU         8'h24
`define EX_BGEU         8'h25
`define EX_JAL          8'h28
`define EX_JALR         8'h29
`define EX_AUIPC        8'h2a

// result select codes
`define RES_NOP         3'b000
`define RES_LOGIC       3'b001
`define RES_SHIFT       3'b010
`define RES_ARITH       3'b011
`define RES_LD_ST       3'b100
`define RES_JAL         3'b101

`endif
